//--- hdl/wr_arb_defs.svh
// Sizes and widths shared by the write arbiter RTL and testbench, pulled in with `include
`ifndef WR_ARB_DEFS_SVH
`define WR_ARB_DEFS_SVH

// Number of request/data sources feeding the arbiter
`define WR_ARB_N_SOURCES 32'd4

// Granted requests whose write data may still be outstanding
`define WR_ARB_QUEUE_DEPTH 32'd4

// Payload field widths
`define WR_ARB_ADDR_W 32
`define WR_ARB_DATA_W 32
`define WR_ARB_BE_W (`WR_ARB_DATA_W / 8)
`define WR_ARB_ID_W 4

// Configuration data word
`define WR_ARB_REG_W 32

// Derived widths, each kept at one bit or more
`define WR_ARB_SEL_W ((`WR_ARB_N_SOURCES > 1) ? $clog2(`WR_ARB_N_SOURCES) : 1)
`define WR_ARB_QPTR_W ((`WR_ARB_QUEUE_DEPTH > 1) ? $clog2(`WR_ARB_QUEUE_DEPTH) : 1)
`define WR_ARB_QCNT_W ($clog2(`WR_ARB_QUEUE_DEPTH + 1))

`endif

//--- hdl/wr_arb_pkg.sv
// Shared types of the write arbiter, referenced by scoped name from the RTL and testbench
`include "wr_arb_defs.svh"

package wr_arb_pkg;

    // Index of one source
    typedef logic [`WR_ARB_SEL_W-1:0] src_sel_t;

    // Write request as seen on every request channel
    typedef struct packed {
        logic [`WR_ARB_ADDR_W-1:0] addr;
        logic [`WR_ARB_ID_W-1:0]   id;
    } mem_req_t;

    // One beat of write data with its byte enables
    typedef struct packed {
        logic [`WR_ARB_DATA_W-1:0] data;
        logic [`WR_ARB_BE_W-1:0]   be;
    } mem_wdata_t;

    // Fixed priority grants the lowest index
    typedef enum logic [0:0] {
        POLICY_FIXED       = 1'b0,
        POLICY_ROUND_ROBIN = 1'b1
    } arb_policy_e;

    typedef enum logic [1:0] {
        REG_POLICY = 2'd0,
        REG_ENABLE = 2'd1
    } cfg_reg_e;

    // One-cycle register access, a write when we is high
    typedef struct packed {
        logic                     we;
        cfg_reg_e                 addr;
        logic [`WR_ARB_REG_W-1:0] wdata;
    } cfg_req_t;

    // Settings that steer the request arbiter
    typedef struct packed {
        arb_policy_e                 policy;
        logic [`WR_ARB_N_SOURCES-1:0] enable;
    } arb_cfg_t;

endpackage

//--- hdl/arb_cfg_regs.sv
// Policy and source enable registers that steer the request arbiter, with readback
`timescale 1ns/1ps
`include "wr_arb_defs.svh"

module arb_cfg_regs (
    input  logic                     clk_i,
    input  logic                     reset_i,

    input  wr_arb_pkg::cfg_req_t     cfg_i,
    output logic [`WR_ARB_REG_W-1:0] cfg_rdata_o,

    output wr_arb_pkg::arb_cfg_t     arb_cfg_o
);

    wr_arb_pkg::arb_policy_e      policy_q;
    logic [`WR_ARB_N_SOURCES-1:0] enable_q;

    // Writes land on the next rising edge
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            policy_q <= wr_arb_pkg::POLICY_FIXED;
            enable_q <= '1;
        end else if (cfg_i.we) begin
            case (cfg_i.addr)
                wr_arb_pkg::REG_POLICY: begin
                    // Only bit 0 selects the policy, the upper bits are ignored
                    policy_q <= wr_arb_pkg::arb_policy_e'(cfg_i.wdata[0]);
                end
                wr_arb_pkg::REG_ENABLE: begin
                    enable_q <= cfg_i.wdata[`WR_ARB_N_SOURCES-1:0];
                end
                default: begin
                    policy_q <= policy_q;
                end
            endcase
        end
    end

    // Readback follows the address in the same cycle
    // Unused upper bits and unmapped addresses read as zero
    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_i.addr)
            wr_arb_pkg::REG_POLICY: begin
                cfg_rdata_o[0] = policy_q;
            end
            wr_arb_pkg::REG_ENABLE: begin
                cfg_rdata_o[`WR_ARB_N_SOURCES-1:0] = enable_q;
            end
            default: begin
                cfg_rdata_o = '0;
            end
        endcase
    end

    always_comb begin
        arb_cfg_o.policy = policy_q;
        arb_cfg_o.enable = enable_q;
    end

endmodule

//--- hdl/req_arbiter.sv
// Request arbiter that picks one source by fixed priority or round robin and reports the winner
`timescale 1ns/1ps
`include "wr_arb_defs.svh"

module req_arbiter (
    input  logic                                         clk_i,
    input  logic                                         reset_i,

    input  wr_arb_pkg::arb_cfg_t                         arb_cfg_i,

    // Source side, one lane per source
    input  logic                 [`WR_ARB_N_SOURCES-1:0] valid_i,
    output logic                 [`WR_ARB_N_SOURCES-1:0] ready_o,
    input  wr_arb_pkg::mem_req_t [`WR_ARB_N_SOURCES-1:0] req_i,

    // Memory side
    output logic                                         valid_o,
    input  logic                                         ready_i,
    output wr_arb_pkg::mem_req_t                         req_o,

    // Index of the source on the output while valid_o is high
    output wr_arb_pkg::src_sel_t                         sel_o
);

    logic [`WR_ARB_N_SOURCES-1:0] masked_valid;

    // Fresh pick from the current requesters
    logic                 pick_found;
    wr_arb_pkg::src_sel_t pick_sel;

    // Round robin start point
    wr_arb_pkg::src_sel_t rr_ptr_q;

    // Choice held across a stalled output
    logic                 lock_q;
    wr_arb_pkg::src_sel_t lock_sel_q;

    wr_arb_pkg::src_sel_t sel;
    logic                 handshake;

    // Disabled sources are invisible to the pick
    assign masked_valid = valid_i & arb_cfg_i.enable;

    // Scan all sources once, starting at index 0 or at the round robin pointer
    always_comb begin
        int unsigned idx;

        pick_found = 1'b0;
        pick_sel   = '0;
        for (int unsigned k = 0; k < `WR_ARB_N_SOURCES; k++) begin
            if (arb_cfg_i.policy == wr_arb_pkg::POLICY_ROUND_ROBIN) begin
                idx = (rr_ptr_q + k) % `WR_ARB_N_SOURCES;
            end else begin
                idx = k;
            end
            if (!pick_found && masked_valid[idx]) begin
                pick_found = 1'b1;
                pick_sel   = wr_arb_pkg::src_sel_t'(idx);
            end
        end
    end

    // A stalled output keeps its source so the payload cannot change under it
    // Nothing is offered to the memory side while reset is held
    assign sel     = lock_q ? lock_sel_q : pick_sel;
    assign valid_o = reset_i ? 1'b0 : (lock_q ? valid_i[lock_sel_q] : pick_found);
    assign req_o   = req_i[sel];
    assign sel_o   = sel;

    assign handshake = valid_o & ready_i;

    always_comb begin
        ready_o      = '0;
        ready_o[sel] = handshake;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lock_q <= 1'b0;
        end else begin
            lock_q <= valid_o & ~ready_i;
        end
    end

    // Source of the current choice, reused in the next cycle when the output stalls
    always_ff @(posedge clk_i) begin
        lock_sel_q <= sel;
    end

    // The pointer moves one past each winner
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q <= '0;
        end else if (handshake) begin
            if (sel == wr_arb_pkg::src_sel_t'(`WR_ARB_N_SOURCES - 1)) begin
                rr_ptr_q <= '0;
            end else begin
                rr_ptr_q <= sel + 1'b1;
            end
        end
    end

endmodule

//--- hdl/wdata_sequencer.sv
// Order queue of granted source indices that releases write data in grant order
`timescale 1ns/1ps
`include "wr_arb_defs.svh"

module wdata_sequencer (
    input  logic                                           clk_i,
    input  logic                                           reset_i,

    // One push per granted request
    input  logic                                           push_i,
    input  wr_arb_pkg::src_sel_t                           push_sel_i,
    output logic                                           space_o,

    // Source data lanes
    input  logic                   [`WR_ARB_N_SOURCES-1:0] valid_i,
    output logic                   [`WR_ARB_N_SOURCES-1:0] ready_o,
    input  wr_arb_pkg::mem_wdata_t [`WR_ARB_N_SOURCES-1:0] wdata_i,

    // Memory side data channel
    output logic                                           valid_o,
    input  logic                                           ready_i,
    output wr_arb_pkg::mem_wdata_t                         wdata_o
);

    wr_arb_pkg::src_sel_t queue_q [`WR_ARB_QUEUE_DEPTH];

    logic [`WR_ARB_QPTR_W-1:0] wr_ptr_q;
    logic [`WR_ARB_QPTR_W-1:0] rd_ptr_q;
    logic [`WR_ARB_QCNT_W-1:0] count_q;

    logic                 not_empty;
    logic                 push;
    logic                 pop;
    wr_arb_pkg::src_sel_t head_sel;

    assign not_empty = (count_q != '0);
    assign space_o   = (count_q != `WR_ARB_QCNT_W'(`WR_ARB_QUEUE_DEPTH));
    assign head_sel  = queue_q[rd_ptr_q];

    // The head entry picks the one source allowed to send data
    // With nothing queued every lane stays blocked
    assign valid_o = not_empty & valid_i[head_sel];
    assign wdata_o = wdata_i[head_sel];

    always_comb begin
        ready_o           = '0;
        ready_o[head_sel] = not_empty & ready_i;
    end

    assign push = push_i & space_o;
    assign pop  = valid_o & ready_i;

    // Index storage, written only on a push
    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_q[wr_ptr_q] <= push_sel_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
        end else if (push) begin
            if (wr_ptr_q == `WR_ARB_QPTR_W'(`WR_ARB_QUEUE_DEPTH - 1)) begin
                wr_ptr_q <= '0;
            end else begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_q <= '0;
        end else if (pop) begin
            if (rd_ptr_q == `WR_ARB_QPTR_W'(`WR_ARB_QUEUE_DEPTH - 1)) begin
                rd_ptr_q <= '0;
            end else begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // A simultaneous push and pop leaves the count unchanged
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (push && !pop) begin
            count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
        end
    end

endmodule

//--- hdl/mem_write_arbiter.sv
// Top level of the write-request arbiter, joining the config registers, arbiter and data queue
`timescale 1ns/1ps
`include "wr_arb_defs.svh"

module mem_write_arbiter (
    input  logic                                           clk_i,
    input  logic                                           reset_i,

    // Per-source request channels
    input  logic                   [`WR_ARB_N_SOURCES-1:0] req_valid_i,
    output logic                   [`WR_ARB_N_SOURCES-1:0] req_ready_o,
    input  wr_arb_pkg::mem_req_t   [`WR_ARB_N_SOURCES-1:0] req_i,

    // Per-source data channels
    input  logic                   [`WR_ARB_N_SOURCES-1:0] wdata_valid_i,
    output logic                   [`WR_ARB_N_SOURCES-1:0] wdata_ready_o,
    input  wr_arb_pkg::mem_wdata_t [`WR_ARB_N_SOURCES-1:0] wdata_i,

    // Memory side request channel
    output logic                                           mem_req_valid_o,
    input  logic                                           mem_req_ready_i,
    output wr_arb_pkg::mem_req_t                           mem_req_o,

    // Memory side data channel
    output logic                                           mem_wdata_valid_o,
    input  logic                                           mem_wdata_ready_i,
    output wr_arb_pkg::mem_wdata_t                         mem_wdata_o,

    // Configuration port
    input  wr_arb_pkg::cfg_req_t                           cfg_i,
    output logic                   [`WR_ARB_REG_W-1:0]     cfg_rdata_o
);

    wr_arb_pkg::arb_cfg_t arb_cfg;

    logic [`WR_ARB_N_SOURCES-1:0] arb_valid;
    logic [`WR_ARB_N_SOURCES-1:0] arb_ready;
    wr_arb_pkg::src_sel_t         grant_sel;

    logic queue_space;
    logic grant_push;

    arb_cfg_regs i_arb_cfg_regs (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .cfg_i       ( cfg_i       ),
        .cfg_rdata_o ( cfg_rdata_o ),
        .arb_cfg_o   ( arb_cfg     )
    );

    // A full queue hides every request from the arbiter and blocks every source
    assign arb_valid   = queue_space ? req_valid_i : '0;
    assign req_ready_o = queue_space ? arb_ready : '0;

    req_arbiter i_req_arbiter (
        .clk_i     ( clk_i           ),
        .reset_i   ( reset_i         ),
        .arb_cfg_i ( arb_cfg         ),
        .valid_i   ( arb_valid       ),
        .ready_o   ( arb_ready       ),
        .req_i     ( req_i           ),
        .valid_o   ( mem_req_valid_o ),
        .ready_i   ( mem_req_ready_i ),
        .req_o     ( mem_req_o       ),
        .sel_o     ( grant_sel       )
    );

    // Every request handshake on the memory side queues the winner's index
    assign grant_push = mem_req_valid_o & mem_req_ready_i;

    wdata_sequencer i_wdata_sequencer (
        .clk_i      ( clk_i             ),
        .reset_i    ( reset_i           ),
        .push_i     ( grant_push        ),
        .push_sel_i ( grant_sel         ),
        .space_o    ( queue_space       ),
        .valid_i    ( wdata_valid_i     ),
        .ready_o    ( wdata_ready_o     ),
        .wdata_i    ( wdata_i           ),
        .valid_o    ( mem_wdata_valid_o ),
        .ready_i    ( mem_wdata_ready_i ),
        .wdata_o    ( mem_wdata_o       )
    );

endmodule

//--- tests/tb_clock_gen.sv
// Free-running testbench clock with a 100 ns period, instantiated by the testbench top
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

endmodule

//--- tests/tb_mem_write_arbiter.sv
// Testbench for mem_write_arbiter that runs the steps of the patterns file against a reference model
`timescale 1ns/1ps
`include "wr_arb_defs.svh"

module tb_mem_write_arbiter;

    localparam int N = `WR_ARB_N_SOURCES;
    localparam int DEPTH = `WR_ARB_QUEUE_DEPTH;

    logic                             clk;
    logic                             reset_i;
    logic                   [N-1:0]   req_valid_i;
    logic                   [N-1:0]   req_ready_o;
    wr_arb_pkg::mem_req_t   [N-1:0]   req_i;
    logic                   [N-1:0]   wdata_valid_i;
    logic                   [N-1:0]   wdata_ready_o;
    wr_arb_pkg::mem_wdata_t [N-1:0]   wdata_i;
    logic                             mem_req_valid_o;
    logic                             mem_req_ready_i;
    wr_arb_pkg::mem_req_t             mem_req_o;
    logic                             mem_wdata_valid_o;
    logic                             mem_wdata_ready_i;
    wr_arb_pkg::mem_wdata_t           mem_wdata_o;
    wr_arb_pkg::cfg_req_t             cfg_i;
    logic [`WR_ARB_REG_W-1:0]         cfg_rdata_o;

    // Reference model state with per-source pending requests and data
    wr_arb_pkg::mem_req_t   req_q [N][$];
    wr_arb_pkg::mem_wdata_t data_q [N][$];
    wr_arb_pkg::mem_wdata_t gdata_q [N][$];
    wr_arb_pkg::mem_wdata_t exp_q [$];
    int                     order_q [$];
    logic [N-1:0]           model_en;
    logic                   model_rr;
    int                     rr_ptr;

    // Pattern steps
    string       ops [$];
    logic [31:0] masks [$];
    logic [31:0] vals [$];
    logic [31:0] bases [$];
    logic [31:0] dseeds [$];

    integer seed = 32'h3a6a736f;
    int     errors;
    int     other_errs;
    int     cycles;
    int     limit = 200;
    int     req_lo;
    int     wd_lo;
    logic   hold_wready;

    tb_clock_gen i_clock_gen (
        .clk_o ( clk )
    );

    mem_write_arbiter i_dut (
        .clk_i             ( clk               ),
        .reset_i           ( reset_i           ),
        .req_valid_i       ( req_valid_i       ),
        .req_ready_o       ( req_ready_o       ),
        .req_i             ( req_i             ),
        .wdata_valid_i     ( wdata_valid_i     ),
        .wdata_ready_o     ( wdata_ready_o     ),
        .wdata_i           ( wdata_i           ),
        .mem_req_valid_o   ( mem_req_valid_o   ),
        .mem_req_ready_i   ( mem_req_ready_i   ),
        .mem_req_o         ( mem_req_o         ),
        .mem_wdata_valid_o ( mem_wdata_valid_o ),
        .mem_wdata_ready_i ( mem_wdata_ready_i ),
        .mem_wdata_o       ( mem_wdata_o       ),
        .cfg_i             ( cfg_i             ),
        .cfg_rdata_o       ( cfg_rdata_o       )
    );

    task automatic check_req(input wr_arb_pkg::mem_req_t got, input wr_arb_pkg::mem_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: mem_req_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_wdata(input wr_arb_pkg::mem_wdata_t got,
                               input wr_arb_pkg::mem_wdata_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: mem_wdata_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: cfg_rdata_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_ready(input string name, input logic [N-1:0] got,
                               input logic [N-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Lowest enabled requester wins, or under round robin the first one at or after the pointer
    function automatic int pick_source();
        int idx;
        for (int k = 0; k < N; k++) begin
            idx = model_rr ? (rr_ptr + k) % N : k;
            if (req_valid_i[idx] && model_en[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    // Inputs change only on the falling edge
    always @(negedge clk) begin
        for (int s = 0; s < N; s++) begin
            req_valid_i[s] = (req_q[s].size() > 0);
            if (req_valid_i[s]) begin
                req_i[s] = req_q[s][0];
            end
            wdata_valid_i[s] = (data_q[s].size() > 0);
            if (wdata_valid_i[s]) begin
                wdata_i[s] = data_q[s][0];
            end
        end
        mem_req_ready_i = (req_lo == 0);
        req_lo = (req_lo == 0) ? ($random(seed) & 1) : req_lo - 1;
        mem_wdata_ready_i = (wd_lo == 0) && !hold_wready;
        wd_lo = (wd_lo == 0) ? ($random(seed) & 1) : wd_lo - 1;
    end

    // Handshakes are observed on the rising edge
    always @(posedge clk) begin
        int                     src;
        logic [N-1:0]           onehot;
        wr_arb_pkg::mem_req_t   old_req;

        cycles++;
        if (cycles > limit) begin
            $display("Run stopped after %0d cycles without finishing", limit);
            $display("Errors: %0d value mismatches, %0d other failures", errors, other_errs + 1);
            $display("Test failed");
            $finish;
        end else if (!reset_i) begin
            // The order queue is not fall-through, so data never leaves on its own grant edge
            if (mem_wdata_valid_o && mem_wdata_ready_i) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Write data left at %0t before its request was granted", $time);
                end else begin
                    src = order_q.pop_front();
                    onehot = '0;
                    onehot[src] = 1'b1;
                    check_wdata(mem_wdata_o, exp_q.pop_front());
                    check_ready("wdata_ready_o", wdata_ready_o, onehot);
                    data_q[src].delete(0);
                end
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                src = pick_source();
                if (src < 0) begin
                    other_errs++;
                    $display("A request was granted at %0t while no source was eligible", $time);
                end else begin
                    old_req = req_q[src].pop_front();
                    check_req(mem_req_o, old_req);
                    onehot = '0;
                    onehot[src] = 1'b1;
                    check_ready("req_ready_o", req_ready_o, onehot);
                    exp_q.push_back(gdata_q[src].pop_front());
                    order_q.push_back(src);
                    rr_ptr = (src + 1) % N;
                end
            end
            if (cfg_i.we && cfg_i.addr == wr_arb_pkg::REG_POLICY) begin
                model_rr = cfg_i.wdata[0];
            end
            if (cfg_i.we && cfg_i.addr == wr_arb_pkg::REG_ENABLE) begin
                model_en = cfg_i.wdata[N-1:0];
            end
        end
    end

    task automatic queue_requests(input logic [31:0] mask, input logic [31:0] base,
                                  input logic [31:0] dseed, input logic [31:0] id);
        wr_arb_pkg::mem_req_t   r;
        wr_arb_pkg::mem_wdata_t d;
        for (int s = 0; s < N; s++) begin
            if (mask[s]) begin
                r.addr = base + s * 32'h100;
                r.id   = `WR_ARB_ID_W'(id + s);
                d.data = dseed ^ (s * 32'h01010101);
                d.be   = `WR_ARB_BE_W'(s + 1);
                req_q[s].push_back(r);
                data_q[s].push_back(d);
                gdata_q[s].push_back(d);
            end
        end
    endtask

    // Disabled sources may stay pending unless every source has to finish
    task automatic wait_drained(input logic all_src);
        logic busy;
        do begin
            @(negedge clk);
            busy = (exp_q.size() != 0);
            for (int s = 0; s < N; s++) begin
                if (all_src || model_en[s]) begin
                    busy = busy || (req_q[s].size() != 0) || (data_q[s].size() != 0);
                end
            end
        end while (busy);
    endtask

    task automatic write_cfg(input logic [31:0] policy, input logic [31:0] en);
        @(negedge clk);
        cfg_i.we    = 1'b1;
        cfg_i.addr  = wr_arb_pkg::REG_POLICY;
        cfg_i.wdata = policy;
        @(negedge clk);
        cfg_i.addr  = wr_arb_pkg::REG_ENABLE;
        cfg_i.wdata = en;
        @(negedge clk);
        cfg_i.we    = 1'b0;
        cfg_i.addr  = wr_arb_pkg::REG_POLICY;
        @(posedge clk);
        check_reg(cfg_rdata_o, {31'b0, policy[0]});
        @(negedge clk);
        cfg_i.addr = wr_arb_pkg::REG_ENABLE;
        @(posedge clk);
        check_reg(cfg_rdata_o, en & ((32'd1 << N) - 1));
    endtask

    initial begin
        int          fd;
        string       line;
        string       op;
        logic [31:0] f_mask;
        logic [31:0] f_val;
        logic [31:0] f_base;
        logic [31:0] f_seed;

        reset_i = 1'b1;
        req_valid_i = '0;
        req_i = '0;
        wdata_valid_i = '0;
        wdata_i = '0;
        mem_req_ready_i = 1'b0;
        mem_wdata_ready_i = 1'b0;
        cfg_i = '0;
        hold_wready = 1'b0;
        model_en = '1;
        model_rr = 1'b0;
        rr_ptr = 0;

        fd = $fopen("tests/write_arb_patterns.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("The patterns file could not be opened");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.substr(0, 0) != "#" &&
                    $sscanf(line, "%s %h %h %h %h", op, f_mask, f_val, f_base, f_seed) == 5) begin
                    ops.push_back(op);
                    masks.push_back(f_mask);
                    vals.push_back(f_val);
                    bases.push_back(f_base);
                    dseeds.push_back(f_seed);
                end
            end
            $fclose(fd);
        end
        limit = 20 * ops.size() + 200;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        foreach (ops[i]) begin
            if (ops[i] == "CFG") begin
                write_cfg(vals[i], masks[i]);
            end else if (ops[i] == "REQ") begin
                @(posedge clk);
                queue_requests(masks[i], bases[i], dseeds[i], vals[i]);
                wait_drained(1'b0);
            end else if (ops[i] == "STALL") begin
                // Two requests per source, more than the order queue can hold
                @(posedge clk);
                hold_wready = 1'b1;
                queue_requests(masks[i], bases[i], dseeds[i], vals[i]);
                queue_requests(masks[i], bases[i] + 32'h80, ~dseeds[i], vals[i] + 8);
                do begin
                    @(negedge clk);
                end while (exp_q.size() < DEPTH);
                repeat (3) begin
                    @(posedge clk);
                    check_ready("req_ready_o", req_ready_o, '0);
                end
                @(negedge clk);
                if (exp_q.size() != DEPTH) begin
                    errors++;
                    $display("ERR %0t: %0d requests accepted, limit %0d", $time, exp_q.size(), DEPTH);
                end
                @(posedge clk);
                hold_wready = 1'b0;
                wait_drained(1'b0);
            end else begin
                other_errs++;
                $display("Unknown opcode %s in step %0d", ops[i], i);
            end
        end
        wait_drained(1'b1);

        $display("Errors: %0d value mismatches, %0d other failures", errors, other_errs);
        if (errors == 0 && other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/write_arb_patterns.txt
# Columns: opcode source_mask value base_address data_seed, all fields in hex
# CFG: mask is the enable mask, value the policy. REQ/STALL: mask picks sources, value the id base
REQ 0000000f 00000000 00001000 a5a50000
REQ 00000005 00000002 00002000 11110000
REQ 0000000c 00000004 00002400 12120000
CFG 0000000f 00000001 00000000 00000000
REQ 0000000f 00000001 00003000 22220000
REQ 0000000f 00000003 00003400 22330000
REQ 0000000a 00000005 00004000 33330000
CFG 0000000b 00000001 00000000 00000000
REQ 0000000f 00000006 00005000 44440000
REQ 00000003 00000007 00006000 55550000
CFG 0000000f 00000000 00000000 00000000
REQ 00000008 00000008 00006800 56560000
STALL 0000000f 00000009 00007000 66660000
CFG 00000006 00000001 00000000 00000000
REQ 00000006 0000000a 00008000 77770000
CFG 0000000f 00000000 00000000 00000000
REQ 0000000f 0000000b 00009000 88880000

//--- compile.f
+incdir+hdl
hdl/wr_arb_pkg.sv
hdl/arb_cfg_regs.sv
hdl/req_arbiter.sv
hdl/wdata_sequencer.sv
hdl/mem_write_arbiter.sv
tests/tb_clock_gen.sv
tests/tb_mem_write_arbiter.sv

//--- Bender.yml
package:
  name: mem_write_arbiter

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wr_arb_pkg.sv
      - hdl/arb_cfg_regs.sv
      - hdl/req_arbiter.sv
      - hdl/wdata_sequencer.sv
      - hdl/mem_write_arbiter.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_mem_write_arbiter.sv
